//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_dcache_state_tracker
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- cache_state_if.sv
//////////////////////////////
// set read and line write path
// read data lags rd_set by one clock
// the write goes to the set on rd_set
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

interface cache_state_if;
  import dcache_pkg::*;

  logic [`CFG_SET_BITS-1:0]         rd_set;
  logic [`CFG_WAYS-1:0]             rd_valid;
  logic [`CFG_WAYS-1:0]             rd_dirty;
  logic [`CFG_WAYS-1:0]             rd_shared;
  logic [`CFG_WAYS-1:0][tag_w-1:0]  rd_tag;

  logic                             wr_en;
  logic [way_w-1:0]                 wr_way;
  line_state_t                      wr_line;

  modport store (
    input  rd_set, wr_en, wr_way, wr_line,
    output rd_valid, rd_dirty, rd_shared, rd_tag
  );

  modport ctrl (
    output rd_set, wr_en, wr_way, wr_line
  );

  modport lookup (
    input  rd_valid, rd_dirty, rd_shared, rd_tag
  );

endinterface

`default_nettype wire

//--- dcache_config.svh
//////////////////////////////
// cache geometry and address map
// sets and ways must stay powers of two
// offset bits only shape the tag split
// no line data is modelled
//////////////////////////////

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

`define CFG_ADDR_WIDTH 32
`define CFG_SET_BITS 4
`define CFG_OFFSET_BITS 4
`define CFG_WAYS 4

// everything below this is uncached
`define CFG_CACHE_BASE 32'h8000_0000

`endif

//--- dcache_pkg.sv
//////////////////////////////
// shared types for the tracker
// only four ACE snoop codes are handled,
// the others are named for decode
//////////////////////////////

`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

  localparam int unsigned tag_w = `CFG_ADDR_WIDTH - `CFG_SET_BITS - `CFG_OFFSET_BITS;
  localparam int unsigned way_w = $clog2(`CFG_WAYS);

  typedef enum logic [1:0] {
    RD_REQ    = 2'd0,
    WR_REQ    = 2'd1,
    SNOOP_REQ = 2'd2
  } req_kind_e;

  // ACE AC channel snoop encodings
  typedef enum logic [3:0] {
    READ_ONCE             = 4'd0,
    READ_SHARED           = 4'd1,
    READ_CLEAN            = 4'd2,
    READ_NOT_SHARED_DIRTY = 4'd3,
    READ_UNIQUE           = 4'd7,
    CLEAN_SHARED          = 4'd8,
    CLEAN_INVALID         = 4'd9,
    MAKE_INVALID          = 4'd13
  } snoop_e;

  typedef struct packed {
    logic [tag_w-1:0]            tag;
    logic [`CFG_SET_BITS-1:0]    set;
    logic [`CFG_OFFSET_BITS-1:0] offset;
  } addr_fields_t;

  // raw for the base compare, fields for the lookup
  typedef union packed {
    logic [`CFG_ADDR_WIDTH-1:0] raw;
    addr_fields_t               f;
  } addr_u;

  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic             valid;
    logic             dirty;
    logic             shared;
  } line_state_t;

endpackage

`default_nettype wire

//--- dcache_state_tracker.sv
//////////////////////////////
// coherence state tracker, tags only
// 16 sets x 4 ways, random replacement
// reply two clocks after the strobe
// no back-pressure on the reply
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_state_tracker (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_req_valid,
  input  dcache_pkg::req_kind_e        i_req_kind,
  input  logic [`CFG_ADDR_WIDTH-1:0]   i_addr,
  input  dcache_pkg::snoop_e           i_snoop,
  output logic                         o_busy,
  output logic                         o_resp_valid,
  output logic                         o_resp_hit,
  output logic                         o_resp_dirty,
  output logic                         o_resp_shared,
  output logic [dcache_pkg::way_w-1:0] o_resp_way,
  output logic                         o_resp_bypass,
  output logic                         o_resp_error,
  output logic                         o_resp_data_transfer
);
  import dcache_pkg::*;

  logic             hit;
  logic [way_w-1:0] hit_way;
  logic             hit_dirty;
  logic             hit_shared;
  logic [way_w-1:0] victim_way;
  logic             alloc;

  cache_state_if cs ();

  tracker_ctrl u_tracker_ctrl (
    .i_clk                (i_clk),
    .i_rst_n              (i_rst_n),
    .i_req_valid          (i_req_valid),
    .i_req_kind           (i_req_kind),
    .i_addr               (i_addr),
    .i_snoop              (i_snoop),
    .i_hit                (hit),
    .i_hit_way            (hit_way),
    .i_hit_dirty          (hit_dirty),
    .i_hit_shared         (hit_shared),
    .i_victim_way         (victim_way),
    .o_alloc              (alloc),
    .sc                   (cs.ctrl),
    .o_busy               (o_busy),
    .o_resp_valid         (o_resp_valid),
    .o_resp_hit           (o_resp_hit),
    .o_resp_dirty         (o_resp_dirty),
    .o_resp_shared        (o_resp_shared),
    .o_resp_way           (o_resp_way),
    .o_resp_bypass        (o_resp_bypass),
    .o_resp_error         (o_resp_error),
    .o_resp_data_transfer (o_resp_data_transfer)
  );

  tag_store u_tag_store (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .st      (cs.store)
  );

  // the write line always carries the tag of the request in flight
  way_lookup u_way_lookup (
    .lk           (cs.lookup),
    .i_tag        (cs.wr_line.tag),
    .o_hit        (hit),
    .o_hit_way    (hit_way),
    .o_hit_dirty  (hit_dirty),
    .o_hit_shared (hit_shared)
  );

  victim_select u_victim_select (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid_v    (cs.rd_valid),
    .i_alloc      (alloc),
    .o_victim_way (victim_way)
  );

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
dcache_pkg.sv
cache_state_if.sv
tag_store.sv
way_lookup.sv
victim_select.sv
tracker_ctrl.sv
dcache_state_tracker.sv
tb_dcache_state_tracker.sv

//--- tag_store.sv
//////////////////////////////
// tag and state bits per set and way
// one read and one write per clock
// a write is seen by the next read
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module tag_store (
  input  logic          i_clk,
  input  logic          i_rst_n,
  cache_state_if.store  st
);
  import dcache_pkg::*;

  localparam int unsigned num_sets = 1 << `CFG_SET_BITS;

  logic [tag_w-1:0]     tag_mem    [num_sets][`CFG_WAYS];
  logic [`CFG_WAYS-1:0] valid_mem  [num_sets];
  logic [`CFG_WAYS-1:0] dirty_mem  [num_sets];
  logic [`CFG_WAYS-1:0] shared_mem [num_sets];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_mem[s] <= '0;
      end
    end else if (st.wr_en) begin
      valid_mem[st.rd_set][st.wr_way] <= st.wr_line.valid;
    end
  end

  // write uses the set that is being read
  always_ff @(posedge i_clk) begin
    if (st.wr_en) begin
      tag_mem[st.rd_set][st.wr_way]    <= st.wr_line.tag;
      dirty_mem[st.rd_set][st.wr_way]  <= st.wr_line.dirty;
      shared_mem[st.rd_set][st.wr_way] <= st.wr_line.shared;
    end
  end

  always_ff @(posedge i_clk) begin
    st.rd_valid  <= valid_mem[st.rd_set];
    st.rd_dirty  <= dirty_mem[st.rd_set];
    st.rd_shared <= shared_mem[st.rd_set];
    for (int w = 0; w < `CFG_WAYS; w++) begin
      st.rd_tag[w] <= tag_mem[st.rd_set][w];
    end
  end

  a_wr_way_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    st.wr_en |-> (!$isunknown(st.wr_way) && (int'(st.wr_way) < `CFG_WAYS)))
    else $error("tag_store write to way %0d", st.wr_way);

endmodule

`default_nettype wire

//--- tb_vectors.svh
//////////////////////////////
// request table for the tracker testbench
// rows run in order and share cache state
// offsets get random low bits at apply time
// flags are hit dirty shared bypass error xfer
//////////////////////////////

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// kind, address, snoop, expected way, expected flags {hit dirty shared bypass error xfer}
task automatic load_vectors();
  // set 1, miss then hit, write path and READ_SHARED
  add_row(RD_REQ,    32'h8000_0010, READ_ONCE,     2'd0, 6'b000000);
  add_row(RD_REQ,    32'h8000_0010, READ_ONCE,     2'd0, 6'b100000);
  add_row(WR_REQ,    32'h8000_1010, READ_ONCE,     2'd1, 6'b000000);
  add_row(WR_REQ,    32'h8000_1010, READ_ONCE,     2'd1, 6'b110000);
  add_row(SNOOP_REQ, 32'h8000_1010, READ_SHARED,   2'd1, 6'b110001);
  add_row(RD_REQ,    32'h8000_1010, READ_ONCE,     2'd1, 6'b111000);
  add_row(WR_REQ,    32'h8000_1010, READ_ONCE,     2'd1, 6'b111000);
  add_row(RD_REQ,    32'h8000_1010, READ_ONCE,     2'd1, 6'b110000);
  add_row(WR_REQ,    32'h8000_0010, READ_ONCE,     2'd0, 6'b100000);
  add_row(RD_REQ,    32'h8000_0010, READ_ONCE,     2'd0, 6'b110000);
  // set 2 filled, then replaced in LFSR order 0, 1, 3
  add_row(RD_REQ,    32'h8000_0020, READ_ONCE,     2'd0, 6'b000000);
  add_row(RD_REQ,    32'h8000_0120, READ_ONCE,     2'd1, 6'b000000);
  add_row(RD_REQ,    32'h8000_0220, READ_ONCE,     2'd2, 6'b000000);
  add_row(WR_REQ,    32'h8000_0320, READ_ONCE,     2'd3, 6'b000000);
  add_row(RD_REQ,    32'h8000_0420, READ_ONCE,     2'd0, 6'b000000);
  add_row(RD_REQ,    32'h8000_0520, READ_ONCE,     2'd1, 6'b000000);
  add_row(RD_REQ,    32'h8000_0420, READ_ONCE,     2'd0, 6'b100000);
  add_row(RD_REQ,    32'h8000_0020, READ_ONCE,     2'd3, 6'b000000);
  add_row(RD_REQ,    32'h8000_0220, READ_ONCE,     2'd2, 6'b100000);
  // set 3, invalidating snoops, READ_ONCE and a snoop miss
  add_row(RD_REQ,    32'h8000_0030, READ_ONCE,     2'd0, 6'b000000);
  add_row(SNOOP_REQ, 32'h8000_0030, READ_UNIQUE,   2'd0, 6'b100001);
  add_row(RD_REQ,    32'h8000_0030, READ_ONCE,     2'd0, 6'b000000);
  add_row(WR_REQ,    32'h8000_0130, READ_ONCE,     2'd1, 6'b000000);
  add_row(SNOOP_REQ, 32'h8000_0130, CLEAN_INVALID, 2'd1, 6'b110000);
  add_row(RD_REQ,    32'h8000_0130, READ_ONCE,     2'd1, 6'b000000);
  add_row(SNOOP_REQ, 32'h8000_0130, READ_ONCE,     2'd1, 6'b100001);
  add_row(RD_REQ,    32'h8000_0130, READ_ONCE,     2'd1, 6'b100000);
  add_row(SNOOP_REQ, 32'h8000_0930, READ_SHARED,   2'd0, 6'b000000);
  // unsupported snoop leaves the line alone
  add_row(SNOOP_REQ, 32'h8000_0010, CLEAN_SHARED,  2'd0, 6'b000010);
  add_row(RD_REQ,    32'h8000_0010, READ_ONCE,     2'd0, 6'b110000);
  // uncached space, nothing stored
  add_row(RD_REQ,    32'h0000_1230, READ_ONCE,     2'd0, 6'b000100);
  add_row(RD_REQ,    32'h0000_1230, READ_ONCE,     2'd0, 6'b000100);
  add_row(WR_REQ,    32'h7fff_fff0, READ_ONCE,     2'd0, 6'b000100);
  add_row(SNOOP_REQ, 32'h7fff_fff0, READ_SHARED,   2'd0, 6'b000100);
  add_row(RD_REQ,    32'h8000_00f0, READ_ONCE,     2'd0, 6'b000000);
endtask

`endif

//--- tb_dcache_state_tracker.sv
//////////////////////////////
// testbench for the state tracker
// inputs change on the falling edge
// each row expects a reply 2 clocks
// after the accepting edge
// stops at the first wrong value
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module tb_dcache_state_tracker;
  import dcache_pkg::*;

  localparam int unsigned wait_limit = 20;

  typedef struct packed {
    req_kind_e                  kind;
    logic [`CFG_ADDR_WIDTH-1:0] addr;
    snoop_e                     snoop;
    logic [way_w-1:0]           way;
    logic [5:0]                 flags;
  } vec_t;

  logic                       i_clk;
  logic                       i_rst_n;
  logic                       i_req_valid;
  req_kind_e                  i_req_kind;
  logic [`CFG_ADDR_WIDTH-1:0] i_addr;
  snoop_e                     i_snoop;
  logic                       o_busy;
  logic                       o_resp_valid;
  logic                       o_resp_hit;
  logic                       o_resp_dirty;
  logic                       o_resp_shared;
  logic [way_w-1:0]           o_resp_way;
  logic                       o_resp_bypass;
  logic                       o_resp_error;
  logic                       o_resp_data_transfer;

  vec_t        vec_table[$];
  int unsigned cur_row;

  dcache_state_tracker u_dcache_state_tracker (
    .i_clk                (i_clk),
    .i_rst_n              (i_rst_n),
    .i_req_valid          (i_req_valid),
    .i_req_kind           (i_req_kind),
    .i_addr               (i_addr),
    .i_snoop              (i_snoop),
    .o_busy               (o_busy),
    .o_resp_valid         (o_resp_valid),
    .o_resp_hit           (o_resp_hit),
    .o_resp_dirty         (o_resp_dirty),
    .o_resp_shared        (o_resp_shared),
    .o_resp_way           (o_resp_way),
    .o_resp_bypass        (o_resp_bypass),
    .o_resp_error         (o_resp_error),
    .o_resp_data_transfer (o_resp_data_transfer)
  );

  always #4 i_clk = ~i_clk;

  task automatic add_row(input req_kind_e kind, input logic [`CFG_ADDR_WIDTH-1:0] addr,
                         input snoop_e snoop, input logic [way_w-1:0] way,
                         input logic [5:0] flags);
    vec_t row;
    row.kind  = kind;
    row.addr  = addr;
    row.snoop = snoop;
    row.way   = way;
    row.flags = flags;
    vec_table.push_back(row);
  endtask

  `include "tb_vectors.svh"

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s on row %0d: got 0x%h expected 0x%h", name, cur_row, got, exp);
      stop_with_failure("first mismatch reached");
    end
  endtask

  // entered and left on a falling edge
  task automatic wait_for_idle();
    int unsigned cycles;
    cycles = 0;
    while (o_busy && cycles < wait_limit) begin
      @(negedge i_clk);
      cycles++;
    end
    if (o_busy) begin
      stop_with_failure($sformatf("DUT still busy after %0d cycles before row %0d",
                                  wait_limit, cur_row));
    end
  endtask

  task automatic apply_row(input int unsigned idx);
    vec_t                       row;
    int unsigned                cycles;
    logic [`CFG_ADDR_WIDTH-1:0] addr;
    row     = vec_table[idx];
    cur_row = idx;
    // offset bits do not matter to the tracker
    addr = row.addr | ($urandom() & 32'h0000_000f);
    wait_for_idle();
    i_req_valid = 1'b1;
    i_req_kind  = row.kind;
    i_addr      = addr;
    i_snoop     = row.snoop;
    @(posedge i_clk);
    @(negedge i_clk);
    i_req_valid = 1'b0;
    cycles = 1;
    while (!o_resp_valid && cycles < wait_limit) begin
      @(negedge i_clk);
      cycles++;
    end
    if (!o_resp_valid) begin
      stop_with_failure($sformatf("no response within %0d cycles on row %0d",
                                  wait_limit, idx));
    end
    check_value("response latency", cycles, 32'd2);
    check_value("o_busy", 32'(o_busy), 32'd1);
    check_value("o_resp_hit", 32'(o_resp_hit), 32'(row.flags[5]));
    check_value("o_resp_dirty", 32'(o_resp_dirty), 32'(row.flags[4]));
    check_value("o_resp_shared", 32'(o_resp_shared), 32'(row.flags[3]));
    check_value("o_resp_bypass", 32'(o_resp_bypass), 32'(row.flags[2]));
    check_value("o_resp_error", 32'(o_resp_error), 32'(row.flags[1]));
    check_value("o_resp_data_transfer", 32'(o_resp_data_transfer), 32'(row.flags[0]));
    check_value("o_resp_way", 32'(o_resp_way), 32'(row.way));
    // one-cycle pulse, busy drops with it
    @(negedge i_clk);
    check_value("o_resp_valid", 32'(o_resp_valid), 32'd0);
    check_value("o_busy", 32'(o_busy), 32'd0);
  endtask

  // strobe held through the busy cycles must not start a second request
  task automatic check_busy_drop();
    int unsigned pulses;
    int unsigned n;
    cur_row = vec_table.size();
    wait_for_idle();
    i_req_valid = 1'b1;
    i_req_kind  = RD_REQ;
    i_addr      = 32'h8000_0010 | ($urandom() & 32'h0000_000f);
    i_snoop     = READ_ONCE;
    @(posedge i_clk);
    pulses = 0;
    for (n = 1; n <= wait_limit; n++) begin
      @(negedge i_clk);
      if (n <= 2) begin
        check_value("o_busy", 32'(o_busy), 32'd1);
      end
      if (n == 3) begin
        i_req_valid = 1'b0;
      end
      if (o_resp_valid) begin
        pulses++;
      end
    end
    check_value("o_resp_valid pulse count", pulses, 32'd1);
  endtask

  initial begin
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req_kind  = RD_REQ;
    i_addr      = '0;
    i_snoop     = READ_ONCE;
    cur_row     = 0;
    void'($urandom(75374));
    load_vectors();

    repeat (8) @(negedge i_clk);
    i_rst_n = 1'b1;
    check_value("o_busy", 32'(o_busy), 32'd0);
    check_value("o_resp_valid", 32'(o_resp_valid), 32'd0);

    for (int unsigned i = 0; i < vec_table.size(); i++) begin
      apply_row(i);
    end
    check_busy_drop();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tracker_ctrl.sv
//////////////////////////////
// one request at a time, two clocks each
// strobes during busy are lost
// response is a pulse, no stall
// snoops other than the four handled
// come back with error set
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module tracker_ctrl (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_req_valid,
  input  dcache_pkg::req_kind_e        i_req_kind,
  input  dcache_pkg::addr_u            i_addr,
  input  dcache_pkg::snoop_e           i_snoop,
  input  logic                         i_hit,
  input  logic [dcache_pkg::way_w-1:0] i_hit_way,
  input  logic                         i_hit_dirty,
  input  logic                         i_hit_shared,
  input  logic [dcache_pkg::way_w-1:0] i_victim_way,
  output logic                         o_alloc,
  cache_state_if.ctrl                  sc,
  output logic                         o_busy,
  output logic                         o_resp_valid,
  output logic                         o_resp_hit,
  output logic                         o_resp_dirty,
  output logic                         o_resp_shared,
  output logic [dcache_pkg::way_w-1:0] o_resp_way,
  output logic                         o_resp_bypass,
  output logic                         o_resp_error,
  output logic                         o_resp_data_transfer
);
  import dcache_pkg::*;

  typedef enum logic [1:0] {IDLE, LOOKUP, RESPOND} state_e;

  state_e    state_q;
  req_kind_e kind_q;
  addr_u     addr_q;
  snoop_e    snoop_q;
  logic      accept;
  logic      bypass;
  logic      snoop_ok;

  assign accept = (state_q == IDLE) && i_req_valid;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    state_q <= accept ? LOOKUP : IDLE;
        LOOKUP:  state_q <= RESPOND;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      kind_q  <= i_req_kind;
      addr_q  <= i_addr;
      snoop_q <= i_snoop;
    end
  end

  assign sc.rd_set = addr_q.f.set;
  assign bypass    = addr_q.raw < `CFG_CACHE_BASE;
  assign snoop_ok  = snoop_q inside {READ_ONCE, READ_SHARED, READ_UNIQUE, CLEAN_INVALID};

  assign o_busy       = (state_q != IDLE);
  assign o_resp_valid = (state_q == RESPOND);

  always_comb begin
    sc.wr_en             = 1'b0;
    sc.wr_way            = i_hit_way;
    sc.wr_line.tag       = addr_q.f.tag;
    sc.wr_line.valid     = 1'b1;
    sc.wr_line.dirty     = i_hit_dirty;
    sc.wr_line.shared    = i_hit_shared;
    o_alloc              = 1'b0;
    o_resp_hit           = 1'b0;
    o_resp_dirty         = 1'b0;
    o_resp_shared        = 1'b0;
    o_resp_way           = '0;
    o_resp_bypass        = 1'b0;
    o_resp_error         = 1'b0;
    o_resp_data_transfer = 1'b0;

    if (o_resp_valid && bypass) begin
      o_resp_bypass = 1'b1;
    end else if (o_resp_valid && kind_q == SNOOP_REQ) begin
      if (!snoop_ok) begin
        o_resp_error = 1'b1;
      end else begin
        // state bits as they were before this snoop
        o_resp_hit           = i_hit;
        o_resp_dirty         = i_hit_dirty;
        o_resp_shared        = i_hit_shared;
        o_resp_way           = i_hit_way;
        o_resp_data_transfer = i_hit && (snoop_q != CLEAN_INVALID);
        if (i_hit && snoop_q == READ_SHARED) begin
          sc.wr_en          = 1'b1;
          sc.wr_line.shared = 1'b1;
        end else if (i_hit && (snoop_q == READ_UNIQUE || snoop_q == CLEAN_INVALID)) begin
          sc.wr_en          = 1'b1;
          sc.wr_line.valid  = 1'b0;
          sc.wr_line.dirty  = 1'b0;
          sc.wr_line.shared = 1'b0;
        end
      end
    end else if (o_resp_valid) begin
      o_resp_hit    = i_hit;
      o_resp_dirty  = i_hit_dirty;
      o_resp_shared = i_hit_shared;
      if (i_hit) begin
        o_resp_way = i_hit_way;
        if (kind_q == WR_REQ) begin
          sc.wr_en          = 1'b1;
          sc.wr_line.dirty  = 1'b1;
          sc.wr_line.shared = 1'b0;
        end
      end else begin
        // fill the victim, a write lands dirty
        o_resp_way        = i_victim_way;
        o_alloc           = 1'b1;
        sc.wr_en          = 1'b1;
        sc.wr_way         = i_victim_way;
        sc.wr_line.dirty  = (kind_q == WR_REQ);
        sc.wr_line.shared = 1'b0;
      end
    end
  end

  a_resp_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_resp_valid |=> !o_resp_valid);

endmodule

`default_nettype wire

//--- victim_select.sv
//////////////////////////////
// fill order is the lowest free way
// a full set falls back to the LFSR,
// which moves only on allocation
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module victim_select (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic [`CFG_WAYS-1:0]         i_valid_v,
  input  logic                         i_alloc,
  output logic [dcache_pkg::way_w-1:0] o_victim_way
);
  import dcache_pkg::*;

  logic [7:0] lfsr_q;
  logic [7:0] lfsr_d;
  logic       full;

  assign full = &i_valid_v;

  // xnor feedback so that zero is not a lock-up state
  assign lfsr_d = {lfsr_q[6:0], ~(lfsr_q[7] ^ lfsr_q[3] ^ lfsr_q[2] ^ lfsr_q[1])};

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      lfsr_q <= '0;
    end else if (i_alloc && full) begin
      lfsr_q <= lfsr_d;
    end
  end

  // walk down so the lowest free way wins
  always_comb begin
    o_victim_way = lfsr_q[way_w-1:0];
    if (!full) begin
      for (int w = `CFG_WAYS - 1; w >= 0; w--) begin
        if (!i_valid_v[w]) begin
          o_victim_way = way_w'(w);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- way_lookup.sv
//////////////////////////////
// tag compare on the registered set
// outputs are zero when nothing hits
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module way_lookup (
  cache_state_if.lookup               lk,
  input  logic [dcache_pkg::tag_w-1:0] i_tag,
  output logic                        o_hit,
  output logic [dcache_pkg::way_w-1:0] o_hit_way,
  output logic                        o_hit_dirty,
  output logic                        o_hit_shared
);
  import dcache_pkg::*;

  logic [`CFG_WAYS-1:0] match_v;

  for (genvar g = 0; g < `CFG_WAYS; g++) begin : g_cmp
    assign match_v[g] = lk.rd_valid[g] && (lk.rd_tag[g] == i_tag);
  end

  // encode the matching way
  always_comb begin
    o_hit_way = '0;
    for (int w = 0; w < `CFG_WAYS; w++) begin
      if (match_v[w]) begin
        o_hit_way = way_w'(w);
      end
    end
  end

  assign o_hit        = |match_v;
  assign o_hit_dirty  = |(match_v & lk.rd_dirty);
  assign o_hit_shared = |(match_v & lk.rd_shared);

  // a tag may live in only one way of a set
  always_comb begin
    if (!$isunknown(match_v)) begin
      a_one_match: assert ($onehot0(match_v))
        else $error("tag %h found in ways %b", i_tag, match_v);
    end
  end

endmodule

`default_nettype wire
